//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= decode_stage_tb
FILELIST  ?= list.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/clock_gen.sv
// 20 ns clock; arst_n is released on the fourth rising edge after time zero
module clock_gen (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held low for four cycles
	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
	end
endmodule

//--- bench/decode_stage_tb.sv
// table-driven test of the decode stage; assumes one-cycle latency and no hazard logic
module decode_stage_tb
	import cpu_types_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		word_t    instr;
		logic     wbw;
		regbits_t sel;
		word_t    data;
		ctrl_t    ctrl;
		regbits_t wdest;
	} entry_t;

	logic clk, arst_n, instr_valid, stall, wb_wen, ex_valid, halted;
	word_t instr, npc, wb_data;
	regbits_t wb_sel;
	id_ex_t id_ex, saved;
	entry_t table_q[$];
	word_t model [32];
	int errors = 0;
	int checks = 0;

	clock_gen u_clock_gen (.clk(clk), .arst_n(arst_n));

	decode_stage u_dut (
		.clk(clk), .arst_n(arst_n), .instr(instr), .instr_valid(instr_valid), .npc(npc),
		.stall(stall), .wb_wen(wb_wen), .wb_sel(wb_sel), .wb_data(wb_data), .id_ex(id_ex),
		.ex_valid(ex_valid), .halted(halted)
	);

	task automatic check(string what, logic [191:0] got, logic [191:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic word_t enc_r(funct_t f, regbits_t rs, regbits_t rt, regbits_t rd);
		return {RTYPE, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic word_t enc_i(opcode_t op, regbits_t rs, regbits_t rt, imm16_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic ctrl_t ctrl_of(mem_to_reg_t m, alu_src_t a, reg_dest_t r, aluop_t op,
			extend_t e, logic dwen, logic dren, logic wen, logic halt, logic dat);
		ctrl_t c;
		c.pc_src = SEL_LOAD_NXT_INSTR;
		c.mem_to_reg = m;
		c.alu_src = a;
		c.reg_dest = r;
		c.alu_op = op;
		c.extend = e;
		c.dwen = dwen;
		c.dren = dren;
		c.wen = wen;
		c.halt = halt;
		c.datomic = dat;
		return c;
	endfunction

	// immediate as the execute stage should see it
	function automatic word_t extend_imm(extend_t e, imm16_t imm);
		if (e == EXT_SIGN)
			return {{16{imm[15]}}, imm};
		else if (e == EXT_UPPER)
			return {imm, 16'h0000};
		return {16'h0000, imm};
	endfunction

	task automatic add(word_t ins, logic wbw, regbits_t sel, word_t data, ctrl_t c,
			regbits_t wd);
		entry_t e;
		e.instr = ins;
		e.wbw = wbw;
		e.sel = sel;
		e.data = data;
		e.ctrl = c;
		e.wdest = wd;
		table_q.push_back(e);
	endtask

	// present one instruction for a single cycle, optionally with a writeback
	task automatic send(word_t ins, word_t pc, logic wbw, regbits_t sel, word_t data);
		@(posedge clk);
		instr <= ins;
		npc <= pc;
		instr_valid <= 1'b1;
		wb_wen <= wbw;
		wb_sel <= sel;
		wb_data <= data;
		@(posedge clk);
		instr_valid <= 1'b0;
		wb_wen <= 1'b0;
	endtask

	task automatic wait_valid(string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!ex_valid && n < 10);
		if (!ex_valid) begin
			errors++;
			$display("timeout: no ex_valid for %s at %0t", what, $time);
		end else begin
			// the record leaves right after the capturing edge
			check({what, " latency"}, 192'(n), 192'(1));
		end
	endtask

	task automatic write_reg(regbits_t sel, word_t data);
		@(posedge clk);
		wb_wen <= 1'b1;
		wb_sel <= sel;
		wb_data <= data;
		@(posedge clk);
		wb_wen <= 1'b0;
		if (sel != 5'd0)
			model[sel] = data;
	endtask

	initial begin
		entry_t e;
		int n;
		instr = '0;
		npc = '0;
		instr_valid = 1'b0;
		stall = 1'b0;
		wb_wen = 1'b0;
		wb_sel = '0;
		wb_data = '0;
		foreach (model[i])
			model[i] = '0;

		// R-type ops write rd
		add(enc_r(SLLV, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_SLL, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(SRLV, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_SRL, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(ADD, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_ADD, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(ADDU, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_ADD, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(SUB, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_SUB, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(SUBU, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_SUB, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(AND, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_AND, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(OR, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_OR, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(XOR, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_XOR, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(NOR, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_NOR, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(SLT, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_SLT, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(SLTU, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_SLTU, EXT_ZERO, 0, 0, 1, 0, 0), 3);
		add(enc_r(JR, 1, 2, 3), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_ADD, EXT_ZERO, 0, 0, 0, 0, 0), 3);
		// immediate 8004 has its top bit set, so rd field reads 16
		add(enc_i(J, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_ADD, EXT_ZERO, 0, 0, 0, 0, 0), 16);
		add(enc_i(JAL, 1, 2, 16'h8004), 0, 0, 0, ctrl_of(SEL_NPC, SEL_REG_DATA,
			SEL_RETURN_REGISTER, ALU_ADD, EXT_ZERO, 0, 0, 1, 0, 0), 31);
		add(enc_i(BEQ, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_SUB, EXT_SIGN, 0, 0, 0, 0, 0), 16);
		add(enc_i(BNE, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_SUB, EXT_SIGN, 0, 0, 0, 0, 0), 16);
		add(enc_i(ADDI, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_IMM16, SEL_RT, ALU_ADD, EXT_SIGN, 0, 0, 1, 0, 0), 2);
		add(enc_i(ADDIU, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_IMM16, SEL_RT, ALU_ADD, EXT_SIGN, 0, 0, 1, 0, 0), 2);
		add(enc_i(SLTI, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RT, ALU_SLT, EXT_SIGN, 0, 0, 1, 0, 0), 2);
		add(enc_i(SLTIU, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RT, ALU_SLTU, EXT_SIGN, 0, 0, 1, 0, 0), 2);
		add(enc_i(ANDI, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_IMM16, SEL_RT, ALU_AND, EXT_ZERO, 0, 0, 1, 0, 0), 2);
		add(enc_i(ORI, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_IMM16, SEL_RT, ALU_OR, EXT_ZERO, 0, 0, 1, 0, 0), 2);
		add(enc_i(XORI, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_IMM16, SEL_RT, ALU_XOR, EXT_ZERO, 0, 0, 1, 0, 0), 2);
		add(enc_i(LUI, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_IMM16, SEL_RT, ALU_ADD, EXT_UPPER, 0, 1, 1, 0, 0), 2);
		add(enc_i(LW, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_DLOAD, SEL_IMM16, SEL_RT, ALU_ADD, EXT_SIGN, 0, 1, 1, 0, 0), 2);
		add(enc_i(LL, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_DLOAD, SEL_IMM16, SEL_RT, ALU_ADD, EXT_SIGN, 0, 1, 1, 0, 1), 2);
		add(enc_i(SW, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_RESULT, SEL_IMM16, SEL_RD, ALU_ADD, EXT_SIGN, 1, 0, 0, 0, 0), 16);
		add(enc_i(SC, 1, 2, 16'h8004), 0, 0, 0,
			ctrl_of(SEL_DLOAD, SEL_IMM16, SEL_RT, ALU_ADD, EXT_SIGN, 1, 0, 1, 0, 1), 2);
		// same-cycle write of r5 must be bypassed, r0 stays zero
		add(enc_r(ADD, 5, 5, 6), 1, 5, 32'ha5a5_0005,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_ADD, EXT_ZERO, 0, 0, 1, 0, 0), 6);
		add(enc_r(ADD, 0, 0, 6), 1, 0, 32'hdead_beef,
			ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD, ALU_ADD, EXT_ZERO, 0, 0, 1, 0, 0), 6);

		n = 0;
		while (!arst_n && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (!arst_n) begin
			errors++;
			$display("timeout: reset was never released");
		end
		check("ex_valid after reset", 192'(ex_valid), 192'(1'b0));
		check("halted after reset", 192'(halted), 192'(1'b0));
		check("id_ex after reset", 192'(id_ex), 192'(1'b0));

		// every register reads zero after reset
		for (int i = 0; i < 32; i++) begin
			send(enc_r(ADD, regbits_t'(i), regbits_t'(31 - i), 3), 32'h0, 1'b0, 5'd0, 32'h0);
			wait_valid("reset read");
			check("reset rdat1", 192'(id_ex.ops.rdat1), 192'(32'h0));
			check("reset rdat2", 192'(id_ex.ops.rdat2), 192'(32'h0));
		end

		write_reg(1, 32'h1234_5678);
		write_reg(2, 32'hcafe_0001);

		foreach (table_q[i]) begin
			e = table_q[i];
			if (e.wbw && e.sel != 5'd0)
				model[e.sel] = e.data;
			send(e.instr, 32'h400 + 32'(i) * 4, e.wbw, e.sel, e.data);
			wait_valid("table entry");
			check("ctrl", 192'(id_ex.ctrl), 192'(e.ctrl));
			check("rdat1", 192'(id_ex.ops.rdat1), 192'(model[e.instr[25:21]]));
			check("rdat2", 192'(id_ex.ops.rdat2), 192'(model[e.instr[20:16]]));
			check("imm_ext", 192'(id_ex.ops.imm_ext),
				192'(extend_imm(e.ctrl.extend, e.instr[15:0])));
			check("wdest", 192'(id_ex.wdest), 192'(e.wdest));
			check("rt", 192'(id_ex.rt), 192'(e.instr[20:16]));
			check("rd", 192'(id_ex.rd), 192'(e.instr[15:11]));
			check("npc", 192'(id_ex.npc), 192'(32'h400 + 32'(i) * 4));
			check("halted", 192'(halted), 192'(1'b0));
		end

		// stall holds the ADDI record while ORI waits at the input
		@(posedge clk);
		instr <= enc_i(ADDI, 1, 2, 16'h0010);
		instr_valid <= 1'b1;
		@(posedge clk);
		instr <= enc_i(ORI, 1, 7, 16'h8000);
		stall <= 1'b1;
		@(negedge clk);
		check("ex_valid before stall", 192'(ex_valid), 192'(1'b1));
		check("alu_op before stall", 192'(id_ex.ctrl.alu_op), 192'(ALU_ADD));
		check("imm_ext before stall", 192'(id_ex.ops.imm_ext), 192'(32'h0000_0010));
		saved = id_ex;
		repeat (2) begin
			@(negedge clk);
			check("ex_valid under stall", 192'(ex_valid), 192'(1'b1));
			check("id_ex under stall", 192'(id_ex), 192'(saved));
		end
		@(posedge clk);
		stall <= 1'b0;
		@(posedge clk);
		instr_valid <= 1'b0;
		@(negedge clk);
		check("ex_valid after stall", 192'(ex_valid), 192'(1'b1));
		check("alu_op after stall", 192'(id_ex.ctrl.alu_op), 192'(ALU_OR));
		check("wdest after stall", 192'(id_ex.wdest), 192'(5'd7));

		// HALT is the last record out
		send(enc_i(HALT, 0, 0, 16'h0), 32'h800, 1'b0, 5'd0, 32'h0);
		wait_valid("halt");
		check("halted with halt record", 192'(halted), 192'(1'b1));
		check("halt ctrl", 192'(id_ex.ctrl), 192'(ctrl_of(SEL_RESULT, SEL_REG_DATA, SEL_RD,
			ALU_ADD, EXT_ZERO, 0, 0, 0, 1, 0)));
		send(enc_r(ADD, 1, 2, 3), 32'h804, 1'b0, 5'd0, 32'h0);
		repeat (5) begin
			@(negedge clk);
			check("ex_valid after halt", 192'(ex_valid), 192'(1'b0));
			check("halted after halt", 192'(halted), 192'(1'b1));
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end
endmodule

//--- common/cpu_types_pkg.sv
// shared types for the decode stage; opcode and funct encodings follow MIPS, other values decode as defaults
package cpu_types_pkg;

	// instruction field widths
	localparam int WORD_W  = 32;
	localparam int OP_W    = 6;
	localparam int FUNCT_W = 6;
	localparam int REG_W   = 5;
	localparam int IMM_W   = 16;

	// plain vector types
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0]  regbits_t;
	typedef logic [IMM_W-1:0]  imm16_t;

	// register file size, register 0 is hardwired to zero
	localparam int REG_COUNT = 32;
	// JAL writes the return address here
	localparam regbits_t RA_REG = 5'd31;

	// primary opcodes, bits 31:26
	typedef enum logic [OP_W-1:0] {
		RTYPE = 6'b000000,
		J     = 6'b000010,
		JAL   = 6'b000011,
		BEQ   = 6'b000100,
		BNE   = 6'b000101,
		ADDI  = 6'b001000,
		ADDIU = 6'b001001,
		SLTI  = 6'b001010,
		SLTIU = 6'b001011,
		ANDI  = 6'b001100,
		ORI   = 6'b001101,
		XORI  = 6'b001110,
		LUI   = 6'b001111,
		LW    = 6'b100011,
		SW    = 6'b101011,
		LL    = 6'b110000,
		SC    = 6'b111000,
		HALT  = 6'b111111
	} opcode_t;

	// R-type function field, bits 5:0
	typedef enum logic [FUNCT_W-1:0] {
		SLLV = 6'b000100,
		SRLV = 6'b000110,
		JR   = 6'b001000,
		ADD  = 6'b100000,
		ADDU = 6'b100001,
		SUB  = 6'b100010,
		SUBU = 6'b100011,
		AND  = 6'b100100,
		OR   = 6'b100101,
		XOR  = 6'b100110,
		NOR  = 6'b100111,
		SLT  = 6'b101010,
		SLTU = 6'b101011
	} funct_t;

	// operation handed to the execute stage ALU
	typedef enum logic [3:0] {
		ALU_SLL  = 4'b0000,
		ALU_SRL  = 4'b0001,
		ALU_ADD  = 4'b0010,
		ALU_SUB  = 4'b0011,
		ALU_AND  = 4'b0100,
		ALU_OR   = 4'b0101,
		ALU_XOR  = 4'b0110,
		ALU_NOR  = 4'b0111,
		ALU_SLT  = 4'b1010,
		ALU_SLTU = 4'b1011
	} aluop_t;

	// second ALU operand
	typedef enum logic {
		SEL_REG_DATA,
		SEL_IMM16
	} alu_src_t;

	// writeback data source
	typedef enum logic [1:0] {
		SEL_RESULT,
		SEL_DLOAD,
		SEL_NPC
	} mem_to_reg_t;

	// which register index gets written
	typedef enum logic [1:0] {
		SEL_RD,
		SEL_RT,
		SEL_RETURN_REGISTER
	} reg_dest_t;

	// only sequential fetch for now, branch targets come with the branch unit
	typedef enum logic [1:0] {
		SEL_LOAD_NXT_INSTR
	} pc_src_t;

	// immediate extension mode, upper puts imm16 in bits 31:16
	typedef enum logic [1:0] {
		EXT_ZERO  = 2'd0,
		EXT_SIGN  = 2'd1,
		EXT_UPPER = 2'd2
	} extend_t;

	// decoded control record
	typedef struct packed {
		pc_src_t     pc_src;
		mem_to_reg_t mem_to_reg;
		alu_src_t    alu_src;
		reg_dest_t   reg_dest;
		aluop_t      alu_op;
		extend_t     extend;
		logic        dwen;
		logic        dren;
		logic        wen;
		logic        halt;
		logic        datomic;
	} ctrl_t;

	// operand record from the register file and extender
	typedef struct packed {
		word_t rdat1;
		word_t rdat2;
		word_t imm_ext;
	} operands_t;

	// registered ID/EX record
	typedef struct packed {
		ctrl_t     ctrl;
		operands_t ops;
		regbits_t  rt;
		regbits_t  rd;
		regbits_t  wdest;
		word_t     npc;
	} id_ex_t;

endpackage

//--- list.f
common/cpu_types_pkg.sv
src/control_unit.sv
src/operand_fetch.sv
src/id_ex_latch.sv
src/decode_stage.sv
bench/clock_gen.sv
bench/decode_stage_tb.sv

//--- src/control_unit.sv
// purely combinational opcode/funct decode; unknown opcodes and functs fall back to the defaults below
module control_unit
	import cpu_types_pkg::*;
(
	input  opcode_t opcode,
	input  funct_t  funct,
	output ctrl_t   ctrl
);

	always_comb begin
		// defaults describe a plain R-type ALU op writing rd
		ctrl.pc_src     = SEL_LOAD_NXT_INSTR;
		ctrl.mem_to_reg = SEL_RESULT;
		ctrl.alu_src    = SEL_REG_DATA;
		ctrl.reg_dest   = SEL_RD;
		ctrl.alu_op     = ALU_ADD;
		ctrl.extend     = EXT_ZERO;
		ctrl.dwen       = 1'b0;
		ctrl.dren       = 1'b0;
		ctrl.wen        = 1'b1;
		ctrl.halt       = 1'b0;
		ctrl.datomic    = 1'b0;

		case (opcode)
			RTYPE: begin
				// R-type alu op comes from the function field
				case (funct)
					SLLV:       ctrl.alu_op = ALU_SLL;
					SRLV:       ctrl.alu_op = ALU_SRL;
					ADD, ADDU:  ctrl.alu_op = ALU_ADD;
					SUB, SUBU:  ctrl.alu_op = ALU_SUB;
					AND:        ctrl.alu_op = ALU_AND;
					OR:         ctrl.alu_op = ALU_OR;
					XOR:        ctrl.alu_op = ALU_XOR;
					NOR:        ctrl.alu_op = ALU_NOR;
					SLT:        ctrl.alu_op = ALU_SLT;
					SLTU:       ctrl.alu_op = ALU_SLTU;
					// jump register writes nothing
					JR:         ctrl.wen = 1'b0;
					default:    ctrl.alu_op = ALU_ADD;
				endcase
			end
			J: ctrl.wen = 1'b0;
			JAL: begin
				// link address goes to r31
				ctrl.mem_to_reg = SEL_NPC;
				ctrl.reg_dest   = SEL_RETURN_REGISTER;
			end
			BEQ, BNE: begin
				// compare by subtraction, offset is signed
				ctrl.wen    = 1'b0;
				ctrl.alu_op = ALU_SUB;
				ctrl.extend = EXT_SIGN;
			end
			ADDI, ADDIU: begin
				ctrl.alu_src  = SEL_IMM16;
				ctrl.reg_dest = SEL_RT;
				ctrl.extend   = EXT_SIGN;
			end
			SLTI, SLTIU: begin
				// alu_src left on register data, as the current datapath expects
				ctrl.reg_dest = SEL_RT;
				ctrl.extend   = EXT_SIGN;
				ctrl.alu_op   = (opcode == SLTI) ? ALU_SLT : ALU_SLTU;
			end
			ANDI, ORI, XORI: begin
				// logical immediates are zero extended
				ctrl.alu_src  = SEL_IMM16;
				ctrl.reg_dest = SEL_RT;
				if (opcode == ANDI)
					ctrl.alu_op = ALU_AND;
				else if (opcode == ORI)
					ctrl.alu_op = ALU_OR;
				else
					ctrl.alu_op = ALU_XOR;
			end
			LUI: begin
				ctrl.alu_src  = SEL_IMM16;
				ctrl.reg_dest = SEL_RT;
				ctrl.dren     = 1'b1;
				ctrl.extend   = EXT_UPPER;
			end
			LW, LL: begin
				// address is base plus signed offset
				ctrl.alu_src    = SEL_IMM16;
				ctrl.reg_dest   = SEL_RT;
				ctrl.mem_to_reg = SEL_DLOAD;
				ctrl.dren       = 1'b1;
				ctrl.extend     = EXT_SIGN;
				ctrl.datomic    = (opcode == LL);
			end
			SW: begin
				ctrl.alu_src = SEL_IMM16;
				ctrl.dwen    = 1'b1;
				ctrl.wen     = 1'b0;
				ctrl.extend  = EXT_SIGN;
			end
			SC: begin
				// store conditional writes its success flag back to rt
				ctrl.alu_src    = SEL_IMM16;
				ctrl.reg_dest   = SEL_RT;
				ctrl.mem_to_reg = SEL_DLOAD;
				ctrl.dwen       = 1'b1;
				ctrl.extend     = EXT_SIGN;
				ctrl.datomic    = 1'b1;
			end
			HALT: begin
				ctrl.wen  = 1'b0;
				ctrl.halt = 1'b1;
			end
			default: ctrl.wen = 1'b1;
		endcase
	end

	// memory side never reads and writes in one access
	always_comb begin
		assert (!(ctrl.dwen && ctrl.dren))
			else $error("control_unit: dwen and dren both set for opcode %0h", opcode);
		// a halting instruction must not disturb the register file
		assert (!(ctrl.halt && ctrl.wen))
			else $error("control_unit: halt decoded together with wen");
	end

endmodule

//--- src/decode_stage.sv
// decode stage top; no hazard or forwarding logic, writeback port is driven from outside
module decode_stage
	import cpu_types_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  word_t    instr,
	input  logic     instr_valid,
	input  word_t    npc,
	input  logic     stall,
	input  logic     wb_wen,
	input  regbits_t wb_sel,
	input  word_t    wb_data,
	output id_ex_t   id_ex,
	output logic     ex_valid,
	output logic     halted
);

	opcode_t   opcode;
	funct_t    funct;
	regbits_t  rs;
	regbits_t  rt;
	regbits_t  rd;
	imm16_t    imm;
	ctrl_t     ctrl;
	operands_t ops;

	// instruction fields, standard MIPS layout
	assign opcode = opcode_t'(instr[31:26]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign imm    = instr[15:0];
	assign funct  = funct_t'(instr[5:0]);

	control_unit u_control_unit (.opcode(opcode), .funct(funct), .ctrl(ctrl));

	// extend mode comes straight from the decoder in the same cycle
	operand_fetch u_operand_fetch (
		.clk(clk), .arst_n(arst_n), .rs(rs), .rt(rt), .imm(imm), .extend(ctrl.extend),
		.wb_wen(wb_wen), .wb_sel(wb_sel), .wb_data(wb_data), .ops(ops)
	);

	id_ex_latch u_id_ex_latch (
		.clk(clk), .arst_n(arst_n), .ctrl(ctrl), .ops(ops), .rt(rt), .rd(rd), .npc(npc),
		.instr_valid(instr_valid), .stall(stall), .id_ex(id_ex), .ex_valid(ex_valid),
		.halted(halted)
	);

endmodule

//--- src/id_ex_latch.sv
// ID/EX register; stall freezes the record, after HALT no further records leave until reset
module id_ex_latch
	import cpu_types_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  ctrl_t     ctrl,
	input  operands_t ops,
	input  regbits_t  rt,
	input  regbits_t  rd,
	input  word_t     npc,
	input  logic      instr_valid,
	input  logic      stall,
	output id_ex_t    id_ex,
	output logic      ex_valid,
	output logic      halted
);

	regbits_t wdest;

	// resolve the write destination here so execute sees one index
	always_comb begin
		case (ctrl.reg_dest)
			SEL_RT:              wdest = rt;
			SEL_RETURN_REGISTER: wdest = RA_REG;
			default:             wdest = rd;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex    <= '0;
			ex_valid <= 1'b0;
			halted   <= 1'b0;
		end else if (halted) begin
			// machine stopped, nothing more leaves the stage
			ex_valid <= 1'b0;
		end else if (!stall) begin
			ex_valid <= instr_valid;
			// record only updates on a valid instruction
			if (instr_valid) begin
				id_ex.ctrl  <= ctrl;
				id_ex.ops   <= ops;
				id_ex.rt    <= rt;
				id_ex.rd    <= rd;
				id_ex.wdest <= wdest;
				id_ex.npc   <= npc;
				halted      <= ctrl.halt;
			end
		end
	end

	// the halt record is the last valid one
	a_no_valid_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> !ex_valid)
		else $error("id_ex_latch: ex_valid high after halted");

endmodule

//--- src/operand_fetch.sv
// 31 writable registers with same-cycle write bypass; writes to register 0 are ignored
module operand_fetch
	import cpu_types_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  regbits_t  rs,
	input  regbits_t  rt,
	input  imm16_t    imm,
	input  extend_t   extend,
	input  logic      wb_wen,
	input  regbits_t  wb_sel,
	input  word_t     wb_data,
	output operands_t ops
);

	// register 0 has no storage
	word_t regs [1:REG_COUNT-1];

	// writeback port, registers cleared on reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb_wen && (wb_sel != '0)) begin
			regs[wb_sel] <= wb_data;
		end
	end

	// one read port, with the pending write forwarded
	function automatic word_t read_reg(regbits_t sel);
		word_t val;
		if (sel == '0)
			val = '0;
		else if (wb_wen && (wb_sel == sel))
			val = wb_data;
		else
			val = regs[sel];
		return val;
	endfunction

	always_comb begin
		ops.rdat1 = read_reg(rs);
		ops.rdat2 = read_reg(rt);
	end

	// immediate extender
	always_comb begin
		case (extend)
			EXT_SIGN:
				ops.imm_ext = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
			// lui value, low half zero
			EXT_UPPER:
				ops.imm_ext = {imm, {(WORD_W-IMM_W){1'b0}}};
			default:
				ops.imm_ext = {{(WORD_W-IMM_W){1'b0}}, imm};
		endcase
	end

	// an unknown write index would silently corrupt some register
	a_wb_sel_known: assert property (@(posedge clk) disable iff (!arst_n)
		wb_wen |-> !$isunknown(wb_sel))
		else $error("operand_fetch: wb_sel unknown during write");

endmodule
